// File: sd_pkg.sv
// widths, register map, command codes and timeouts for the SD block reader
// enum types for the status and the three FSMs, CRC7 update step
package sd_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] sector_t;
	typedef logic [31:0] count_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [37:0] cmd_frame_t;
	typedef logic [47:0] reply_t;
	typedef logic [6:0]  part_idx_t;
	typedef logic [6:0]  crc7_t;
	typedef logic [15:0] crc16_t;

	typedef enum logic [1:0] {
		STATUS_IDLE  = 2'd0,
		STATUS_READ  = 2'd1,
		STATUS_ERROR = 2'd2
	} status_t;

	typedef enum logic [1:0] {
		S_CTRL_IDLE, S_CTRL_READ_BLOCK, S_CTRL_ADVANCE, S_CTRL_ERROR
	} ctrl_state_t;

	typedef enum logic [3:0] {
		S_CMD_IDLE, S_CMD_PREAMBLE, S_CMD_START_BIT, S_CMD_HOST_BIT, S_CMD_BODY,
		S_CMD_CRC, S_CMD_END_BIT, S_CMD_RELEASE, S_CMD_WAIT_REPLY, S_CMD_REPLY, S_CMD_TAIL
	} cmd_state_t;

	typedef enum logic [2:0] {
		S_DATA_IDLE, S_DATA_START, S_DATA_WORD, S_DATA_SETTLE, S_DATA_PRESENT,
		S_DATA_CRC, S_DATA_END
	} data_state_t;

	localparam reg_addr_t REG_BASE    = 2'd0;
	localparam reg_addr_t REG_SECTOR  = 2'd1;
	localparam reg_addr_t REG_COUNT   = 2'd2;
	localparam reg_addr_t REG_CONTROL = 2'd3;

	localparam logic [1:0] CONTROL_IDLE = 2'd0;
	localparam logic [1:0] CONTROL_READ = 2'd2;

	localparam logic [5:0] CMD_READ_SINGLE = 6'd17;

	localparam int BLOCK_BYTES        = 512;
	localparam int WORD_BITS          = 32;
	localparam int WORDS_PER_BLOCK    = 128;
	localparam int CMD_BODY_BITS      = 38;
	localparam int REPLY_BITS         = 48;
	localparam int CMD_PREAMBLE_ONES  = 8;
	localparam int REPLY_TIMEOUT      = 255;
	localparam int DATA_START_TIMEOUT = 65535;
	localparam int REPLY_TAIL_ONES    = 8;
	localparam int SD_CLK_DIV         = 4;

	// R1 card status bits that flag an error (APP_CMD and AKE_SEQ_ERROR included)
	localparam word_t R1_ERROR_MASK = 32'hfff9_e028;

	// one CRC7 step, register kept bit-reversed so bit 0 goes out first
	function automatic crc7_t crc7_next(crc7_t crc, logic din);
		logic fb;
		fb = din ^ crc[0];
		return {fb, crc[6:5], crc[4] ^ fb, crc[3:1]};
	endfunction

endpackage

// File: sd_clock_gen.sv
// SD clock divider, gated by the engines' requests
// sd_tick marks the phase where the engines sample and drive
module sd_clock_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_clk_req,
	input  logic data_clk_req,
	input  logic data_hold,
	output logic sd_clk,
	output logic sd_tick
);
	import sd_pkg::*;

	logic [$clog2(SD_CLK_DIV)-1:0] phase;

	// parks at phase zero when nobody needs the clock or a word is waiting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase != '0) begin
			phase <= phase + 1'b1;
		end else if ((cmd_clk_req || data_clk_req) && !data_hold) begin
			phase <= phase + 1'b1;
		end
	end

	// high in the upper half of the period
	assign sd_clk  = phase[$high(phase)];
	assign sd_tick = (phase == '0) && !data_hold;

endmodule

// File: sd_cmd_engine.sv
// command line engine: preamble, 48-bit command with CRC7, then
// waits for and collects the 48-bit reply, with a start-bit timeout
module sd_cmd_engine (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sd_tick,
	input  logic              cmd_start,
	input  sd_pkg::cmd_frame_t cmd_frame,
	output logic              cmd_done,
	output logic              cmd_timeout,
	output sd_pkg::reply_t    reply,
	output logic              cmd_clk_req,
	output logic              sd_cmd_out,
	output logic              sd_cmd_oe,
	input  logic              sd_cmd_in
);
	import sd_pkg::*;

	cmd_state_t state;
	logic [7:0] cnt;
	cmd_frame_t tx_shift;
	crc7_t      crc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_CMD_IDLE;
			cnt         <= '0;
			cmd_done    <= 1'b0;
			cmd_timeout <= 1'b0;
			sd_cmd_out  <= 1'b1;
			sd_cmd_oe   <= 1'b0;
		end else begin
			cmd_done    <= 1'b0;
			cmd_timeout <= 1'b0;
			if (state == S_CMD_IDLE) begin
				if (cmd_start) begin
					tx_shift <= cmd_frame;
					cnt      <= '0;
					state    <= S_CMD_PREAMBLE;
				end
			end else if (sd_tick) begin
				case (state)
					S_CMD_PREAMBLE: begin
						sd_cmd_oe  <= 1'b1;
						sd_cmd_out <= 1'b1;
						crc        <= '0;
						if (cnt == 8'(CMD_PREAMBLE_ONES - 1)) begin
							cnt   <= '0;
							state <= S_CMD_START_BIT;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					S_CMD_START_BIT: begin
						sd_cmd_out <= 1'b0;
						crc        <= crc7_next(crc, 1'b0);
						state      <= S_CMD_HOST_BIT;
					end
					S_CMD_HOST_BIT: begin
						sd_cmd_out <= 1'b1;
						crc        <= crc7_next(crc, 1'b1);
						state      <= S_CMD_BODY;
					end
					S_CMD_BODY: begin
						sd_cmd_out <= tx_shift[CMD_BODY_BITS-1];
						crc        <= crc7_next(crc, tx_shift[CMD_BODY_BITS-1]);
						tx_shift   <= {tx_shift[CMD_BODY_BITS-2:0], 1'b0};
						if (cnt == 8'(CMD_BODY_BITS - 1)) begin
							cnt   <= '0;
							state <= S_CMD_CRC;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					S_CMD_CRC: begin
						sd_cmd_out <= crc[0];
						crc        <= {1'b0, crc[6:1]};
						if (cnt == 8'($bits(crc7_t) - 1)) begin
							cnt   <= '0;
							state <= S_CMD_END_BIT;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					S_CMD_END_BIT: begin
						sd_cmd_out <= 1'b1;
						state      <= S_CMD_RELEASE;
					end
					// end bit has been clocked, hand the line to the card
					S_CMD_RELEASE: begin
						sd_cmd_oe <= 1'b0;
						state     <= S_CMD_WAIT_REPLY;
					end
					S_CMD_WAIT_REPLY: begin
						if (!sd_cmd_in) begin
							reply <= {reply[REPLY_BITS-2:0], 1'b0};
							cnt   <= '0;
							state <= S_CMD_REPLY;
						end else if (cnt == 8'(REPLY_TIMEOUT - 1)) begin
							cmd_done    <= 1'b1;
							cmd_timeout <= 1'b1;
							state       <= S_CMD_IDLE;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					S_CMD_REPLY: begin
						reply <= {reply[REPLY_BITS-2:0], sd_cmd_in};
						if (cnt == 8'(REPLY_BITS - 2)) begin
							cnt   <= '0;
							state <= S_CMD_TAIL;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					S_CMD_TAIL: begin
						if (cnt == 8'(REPLY_TAIL_ONES - 1)) begin
							cmd_done <= 1'b1;
							state    <= S_CMD_IDLE;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end
					default: state <= S_CMD_IDLE;
				endcase
			end
		end
	end

	assign cmd_clk_req = (state != S_CMD_IDLE);

endmodule

// File: sd_data_reader.sv
// DAT0 block receiver for the start bit, 128 words of 32 bits, CRC16 and end bit
// each word is presented and the SD clock held until it is taken
module sd_data_reader (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sd_tick,
	input  logic               read_start,
	input  logic               sd_dat0_in,
	output sd_pkg::word_t      word,
	output sd_pkg::part_idx_t  part_idx,
	output logic               word_valid,
	input  logic               word_taken,
	output logic               data_hold,
	output logic               data_clk_req,
	output logic               block_done,
	output logic               block_ok
);
	import sd_pkg::*;

	data_state_t state;
	logic [15:0] cnt;
	crc16_t      crc;
	crc16_t      crc_rx;

	// CRC16-CCITT step taken MSB first
	function automatic crc16_t crc16_next(crc16_t c, logic din);
		logic fb;
		fb = din ^ c[15];
		return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_DATA_IDLE;
			cnt        <= '0;
			part_idx   <= '0;
			word_valid <= 1'b0;
			block_done <= 1'b0;
			block_ok   <= 1'b0;
		end else begin
			block_done <= 1'b0;
			case (state)
				S_DATA_IDLE: begin
					if (read_start) begin
						cnt      <= '0;
						crc      <= '0;
						part_idx <= '0;
						state    <= S_DATA_START;
					end
				end
				S_DATA_START: begin
					if (sd_tick) begin
						if (!sd_dat0_in) begin
							cnt   <= '0;
							state <= S_DATA_WORD;
						end else if (cnt == 16'(DATA_START_TIMEOUT - 1)) begin
							block_done <= 1'b1;
							block_ok   <= 1'b0;
							state      <= S_DATA_IDLE;
						end else begin
							cnt <= cnt + 16'd1;
						end
					end
				end
				S_DATA_WORD: begin
					if (sd_tick) begin
						word <= {word[WORD_BITS-2:0], sd_dat0_in};
						crc  <= crc16_next(crc, sd_dat0_in);
						if (cnt == 16'(WORD_BITS - 1)) begin
							cnt   <= '0;
							state <= S_DATA_SETTLE;
						end else begin
							cnt <= cnt + 16'd1;
						end
					end
				end
				// let the running SD clock period finish, so the card puts the
				// next bit out and the hold starts at phase zero
				S_DATA_SETTLE: begin
					if (cnt == 16'(SD_CLK_DIV - 2)) begin
						word_valid <= 1'b1;
						state      <= S_DATA_PRESENT;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				S_DATA_PRESENT: begin
					if (word_taken) begin
						word_valid <= 1'b0;
						cnt        <= '0;
						if (part_idx == part_idx_t'(WORDS_PER_BLOCK - 1)) begin
							state <= S_DATA_CRC;
						end else begin
							part_idx <= part_idx + 1'b1;
							state    <= S_DATA_WORD;
						end
					end
				end
				S_DATA_CRC: begin
					if (sd_tick) begin
						crc_rx <= {crc_rx[14:0], sd_dat0_in};
						if (cnt == 16'($bits(crc16_t) - 1)) begin
							state <= S_DATA_END;
						end else begin
							cnt <= cnt + 16'd1;
						end
					end
				end
				S_DATA_END: begin
					if (sd_tick) begin
						block_done <= 1'b1;
						block_ok   <= (crc_rx == crc) && sd_dat0_in;
						state      <= S_DATA_IDLE;
					end
				end
				default: state <= S_DATA_IDLE;
			endcase
		end
	end

	assign data_hold    = word_valid;
	assign data_clk_req = (state != S_DATA_IDLE);

endmodule

// File: sd_bus_master.sv
// Avalon master that writes each received word to memory
// address is the block base plus the word offset, bytes reversed
module sd_bus_master (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              word_valid,
	input  sd_pkg::word_t     word,
	input  sd_pkg::part_idx_t part_idx,
	input  sd_pkg::word_t     mem_base,
	output logic              word_taken,
	output sd_pkg::word_t     avm_address,
	output logic              avm_write,
	output sd_pkg::word_t     avm_writedata,
	input  logic              avm_waitrequest
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			avm_write <= 1'b0;
		end else if (avm_write) begin
			if (!avm_waitrequest) begin
				avm_write <= 1'b0;
			end
		end else if (word_valid) begin
			avm_write <= 1'b1;
		end
	end

	// payload loads only while no write is outstanding
	always_ff @(posedge clk) begin
		if (!avm_write && word_valid) begin
			avm_address   <= mem_base + {23'd0, part_idx, 2'b00};
			avm_writedata <= {word[7:0], word[15:8], word[23:16], word[31:24]};
		end
	end

	// reader drops word_valid on the next cycle
	assign word_taken = avm_write && !avm_waitrequest;

endmodule

// File: sd_read_ctrl.sv
// host register file and status, per-block CMD17 read sequence
// R1 reply check with a local CRC7, block register advance
module sd_read_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  sd_pkg::reg_addr_t   avs_address,
	input  logic                avs_read,
	input  logic                avs_write,
	input  sd_pkg::word_t       avs_writedata,
	output sd_pkg::word_t       avs_readdata,
	output logic                avs_waitrequest,
	output sd_pkg::word_t       mem_base,
	output logic                cmd_start,
	output sd_pkg::cmd_frame_t  cmd_frame,
	input  logic                cmd_done,
	input  logic                cmd_timeout,
	input  sd_pkg::reply_t      reply,
	output logic                read_start,
	input  logic                block_done,
	input  logic                block_ok
);
	import sd_pkg::*;

	ctrl_state_t state;
	status_t     status;
	sector_t     sector;
	count_t      count;
	logic [1:0]  control;
	logic        cmd_seen, cmd_ok, blk_seen, blk_ok;
	crc7_t       crc_calc;
	logic        reply_good;
	logic        cmd_seen_now, cmd_ok_now, blk_seen_now, blk_ok_now;

	// CRC7 over start, transmission, index and argument bits
	function automatic crc7_t reply_crc(reply_t r);
		crc7_t c;
		c = '0;
		for (int i = REPLY_BITS - 1; i >= 8; i--) begin
			c = crc7_next(c, r[i]);
		end
		return c;
	endfunction

	assign crc_calc   = reply_crc(reply);
	assign reply_good = (reply[47:46] == 2'b00) && (reply[45:40] == CMD_READ_SINGLE) &&
		((reply[39:8] & R1_ERROR_MASK) == '0) &&
		(reply[7:1] == {crc_calc[0], crc_calc[1], crc_calc[2], crc_calc[3],
			crc_calc[4], crc_calc[5], crc_calc[6]}) &&
		reply[0];

	// results may arrive in either order or in the same cycle
	assign cmd_seen_now = cmd_seen || cmd_done;
	assign cmd_ok_now   = cmd_done ? (!cmd_timeout && reply_good) : cmd_ok;
	assign blk_seen_now = blk_seen || block_done;
	assign blk_ok_now   = block_done ? block_ok : blk_ok;

	assign avs_waitrequest = (state == S_CTRL_ADVANCE);
	assign avs_readdata    = (avs_read && avs_address == REG_BASE) ? word_t'(status) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_base <= '0;
			sector   <= '0;
			count    <= '0;
			control  <= CONTROL_IDLE;
		end else if (state == S_CTRL_ADVANCE) begin
			mem_base <= mem_base + word_t'(BLOCK_BYTES);
			sector   <= sector + 1'b1;
			count    <= count - 1'b1;
			if (count == count_t'(1)) begin
				control <= CONTROL_IDLE;
			end
		end else if (avs_write) begin
			case (avs_address)
				REG_BASE:    mem_base <= avs_writedata;
				REG_SECTOR:  sector   <= avs_writedata;
				REG_COUNT:   count    <= avs_writedata;
				REG_CONTROL: control  <= avs_writedata[1:0];
				default:     ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_CTRL_IDLE;
			status     <= STATUS_IDLE;
			cmd_start  <= 1'b0;
			read_start <= 1'b0;
			cmd_seen   <= 1'b0;
			cmd_ok     <= 1'b0;
			blk_seen   <= 1'b0;
			blk_ok     <= 1'b0;
		end else begin
			cmd_start  <= 1'b0;
			read_start <= 1'b0;
			case (state)
				S_CTRL_IDLE: begin
					if (control == CONTROL_READ && count != '0) begin
						cmd_frame  <= {CMD_READ_SINGLE, sector};
						cmd_start  <= 1'b1;
						read_start <= 1'b1;
						status     <= STATUS_READ;
						state      <= S_CTRL_READ_BLOCK;
					end else begin
						status <= STATUS_IDLE;
					end
				end
				S_CTRL_READ_BLOCK: begin
					cmd_seen <= cmd_seen_now;
					cmd_ok   <= cmd_ok_now;
					blk_seen <= blk_seen_now;
					blk_ok   <= blk_ok_now;
					if (cmd_seen_now && blk_seen_now) begin
						cmd_seen <= 1'b0;
						blk_seen <= 1'b0;
						if (cmd_ok_now && blk_ok_now) begin
							state <= S_CTRL_ADVANCE;
						end else begin
							status <= STATUS_ERROR;
							state  <= S_CTRL_ERROR;
						end
					end
				end
				// next block starts from idle if control still says read
				S_CTRL_ADVANCE: state <= S_CTRL_IDLE;
				S_CTRL_ERROR: begin
					if (control == CONTROL_IDLE) begin
						status <= STATUS_IDLE;
						state  <= S_CTRL_IDLE;
					end
				end
				default: state <= S_CTRL_IDLE;
			endcase
		end
	end

endmodule

// File: sd_block_reader.sv
// SD block reader top level: Avalon slave and master, 1-bit SD card pins
// clock gen, command engine, data reader, bus master and controller
module sd_block_reader (
	input  logic              clk,
	input  logic              rst_n,
	input  sd_pkg::reg_addr_t avs_address,
	input  logic              avs_read,
	output sd_pkg::word_t     avs_readdata,
	input  logic              avs_write,
	input  sd_pkg::word_t     avs_writedata,
	output logic              avs_waitrequest,
	output sd_pkg::word_t     avm_address,
	output logic              avm_write,
	output sd_pkg::word_t     avm_writedata,
	input  logic              avm_waitrequest,
	output logic              sd_clk,
	output logic              sd_cmd_out,
	output logic              sd_cmd_oe,
	input  logic              sd_cmd_in,
	input  logic              sd_dat0_in
);
	import sd_pkg::*;

	logic       sd_tick, cmd_clk_req, data_clk_req, data_hold;
	logic       cmd_start, cmd_done, cmd_timeout;
	cmd_frame_t cmd_frame;
	reply_t     reply;
	logic       read_start, block_done, block_ok;
	word_t      word, mem_base;
	part_idx_t  part_idx;
	logic       word_valid, word_taken;

	sd_clock_gen u_clock_gen (
		.clk, .rst_n, .cmd_clk_req, .data_clk_req, .data_hold, .sd_clk, .sd_tick
	);

	sd_cmd_engine u_cmd_engine (
		.clk, .rst_n, .sd_tick, .cmd_start, .cmd_frame, .cmd_done, .cmd_timeout,
		.reply, .cmd_clk_req, .sd_cmd_out, .sd_cmd_oe, .sd_cmd_in
	);

	sd_data_reader u_data_reader (
		.clk, .rst_n, .sd_tick, .read_start, .sd_dat0_in, .word, .part_idx,
		.word_valid, .word_taken, .data_hold, .data_clk_req, .block_done, .block_ok
	);

	sd_bus_master u_bus_master (
		.clk, .rst_n, .word_valid, .word, .part_idx, .mem_base, .word_taken,
		.avm_address, .avm_write, .avm_writedata, .avm_waitrequest
	);

	sd_read_ctrl u_read_ctrl (
		.clk, .rst_n, .avs_address, .avs_read, .avs_write, .avs_writedata,
		.avs_readdata, .avs_waitrequest, .mem_base, .cmd_start, .cmd_frame,
		.cmd_done, .cmd_timeout, .reply, .read_start, .block_done, .block_ok
	);

endmodule

// File: sd_block_reader_asserts.sv
// concurrent checks on the SD block reader top level
// SD clock freeze, master write stability, command start while busy
module sd_block_reader_asserts (
	input logic          clk,
	input logic          rst_n,
	input logic          sd_clk,
	input logic          data_hold,
	input logic          avm_write,
	input logic          avm_waitrequest,
	input sd_pkg::word_t avm_address,
	input sd_pkg::word_t avm_writedata,
	input logic          cmd_start,
	input logic          cmd_clk_req
);

	a_clk_held: assert property (@(posedge clk) disable iff (!rst_n)
		data_hold |-> !sd_clk)
		else $error("sd_clk high while a word is held");

	a_write_stable: assert property (@(posedge clk) disable iff (!rst_n)
		avm_write && avm_waitrequest |=> avm_write && $stable(avm_address) &&
		$stable(avm_writedata))
		else $error("master write changed under waitrequest");

	// engine busy whenever it requests the clock
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_start |-> !cmd_clk_req)
		else $error("cmd_start while command engine busy");

endmodule

// File: sd_card_model.sv
// behavioural SD card that answers CMD17 in 1-bit mode
// checks the command CRC7, replies with R1, then sends a sector-derived block
// fault codes: 1 bad CRC16, 2 bad end bit, 3 silent, 4 bad reply CRC7
module sd_card_model (
	input  logic        sd_clk,
	input  logic        sd_cmd_out,
	input  logic        sd_cmd_oe,
	output logic        sd_cmd_in,
	output logic        sd_dat0_in,
	input  logic [2:0]  fault,
	output logic [5:0]  last_index,
	output logic [31:0] last_arg,
	output int          cmd_count,
	output int          cmd_crc_bad
);
	logic [47:0] frame;
	logic [47:0] resp;
	logic [15:0] dcrc;
	logic [31:0] w;

	// CRC7 x^7+x^3+1, MSB first
	function automatic logic [6:0] crc7_of(logic [39:0] d);
		logic [6:0] c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = d[i] ^ c[6];
			c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return c;
	endfunction

	function automatic logic [15:0] crc16_step(logic [15:0] c, logic din);
		logic fb;
		fb = din ^ c[15];
		return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
	endfunction

	// card contents, a function of sector and word index
	function automatic logic [31:0] block_word(logic [31:0] sector, int idx);
		return (sector * 32'h9e37_79b9) ^ {idx[7:0], idx[7:0] ^ 8'ha5, sector[15:0] + 16'(idx)};
	endfunction

	task automatic send_reply();
		resp = {2'b00, 6'd17, 32'h0000_0900, 7'd0, 1'b1};
		resp[7:1] = crc7_of(resp[47:8]);
		if (fault == 3'd4) begin
			resp[1] = ~resp[1];
		end
		repeat (2) @(negedge sd_clk);
		for (int k = 47; k >= 0; k--) begin
			@(negedge sd_clk);
			sd_cmd_in = resp[k];
		end
		@(negedge sd_clk);
		sd_cmd_in = 1'b1;
	endtask

	task automatic send_block(logic [31:0] sector);
		dcrc = '0;
		repeat (2) @(negedge sd_clk);
		@(negedge sd_clk);
		sd_dat0_in = 1'b0;
		for (int i = 0; i < 128; i++) begin
			w = block_word(sector, i);
			for (int b = 31; b >= 0; b--) begin
				@(negedge sd_clk);
				sd_dat0_in = w[b];
				dcrc = crc16_step(dcrc, w[b]);
			end
		end
		if (fault == 3'd1) begin
			dcrc[0] = ~dcrc[0];
		end
		for (int b = 15; b >= 0; b--) begin
			@(negedge sd_clk);
			sd_dat0_in = dcrc[b];
		end
		@(negedge sd_clk);
		sd_dat0_in = (fault != 3'd2);
		@(negedge sd_clk);
		sd_dat0_in = 1'b1;
	endtask

	initial begin
		sd_cmd_in = 1'b1;
		sd_dat0_in = 1'b1;
		last_index = '0;
		last_arg = '0;
		cmd_count = 0;
		cmd_crc_bad = 0;
		forever begin
			@(posedge sd_clk);
			// start bit of a host command
			if (sd_cmd_oe && !sd_cmd_out) begin
				frame[47] = 1'b0;
				for (int k = 46; k >= 0; k--) begin
					@(posedge sd_clk);
					frame[k] = sd_cmd_out;
				end
				last_index = frame[45:40];
				last_arg = frame[39:8];
				cmd_count++;
				if (frame[7:1] != crc7_of(frame[47:8]) || !frame[0] || !frame[46]) begin
					cmd_crc_bad++;
				end
				if (fault != 3'd3) begin
					send_reply();
					send_block(frame[39:8]);
				end
			end
		end
	end

endmodule

// File: tb_sd_block_reader.sv
// testbench for the SD block reader with clock, reset, host and memory models
// random single and multi-block reads, back-pressure and card faults
module tb_sd_block_reader;
	import sd_pkg::*;

	logic       clk;
	logic       rst_n;
	reg_addr_t  avs_address;
	logic       avs_read, avs_write, avs_waitrequest;
	word_t      avs_readdata, avs_writedata;
	word_t      avm_address, avm_writedata;
	logic       avm_write;
	logic       avm_waitrequest = 1'b0;
	logic       sd_clk, sd_cmd_out, sd_cmd_oe, sd_cmd_in, sd_dat0_in;
	logic [2:0] fault;
	logic [5:0] card_index;
	sector_t    card_arg;
	int         card_cmds, card_crc_bad;
	word_t      mem [word_t];
	int         writes [word_t];
	int         wait_pct = 0;
	int         advance_cycles = 0;
	int         errors = 0;

	sd_block_reader dut0 (.*);

	sd_card_model card0 (
		.sd_clk, .sd_cmd_out, .sd_cmd_oe, .sd_cmd_in, .sd_dat0_in, .fault,
		.last_index(card_index), .last_arg(card_arg), .cmd_count(card_cmds),
		.cmd_crc_bad(card_crc_bad)
	);

	bind sd_block_reader sd_block_reader_asserts asrt0 (
		.clk(clk), .rst_n(rst_n), .sd_clk(sd_clk), .data_hold(data_hold),
		.avm_write(avm_write), .avm_waitrequest(avm_waitrequest),
		.avm_address(avm_address), .avm_writedata(avm_writedata),
		.cmd_start(cmd_start), .cmd_clk_req(cmd_clk_req)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory model that counts every accepted write per address
	always @(posedge clk) begin
		if (rst_n && avm_write && !avm_waitrequest) begin
			mem[avm_address] = avm_writedata;
			if (writes.exists(avm_address)) begin
				writes[avm_address]++;
			end else begin
				writes[avm_address] = 1;
			end
		end
	end

	// counts slave waitrequest cycles from the block advances
	always @(posedge clk) begin
		if (rst_n && avs_waitrequest) begin
			advance_cycles++;
		end
	end

	always @(negedge clk) begin
		avm_waitrequest <= ($urandom % 100) < wait_pct;
	end

	task automatic stop_run();
		errors++;
		$display("Finished with errors");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_failure(string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_status(string what, status_t got, status_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %s expected %s", $time, what,
				got.name(), exp.name());
			stop_run();
		end
	endtask

	task automatic check_word(string what, word_t got, word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_sector(string what, sector_t got, sector_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_reply(string what, reply_t got, reply_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// reference CRC7 with x^7+x^3+1 taken MSB first
	function automatic crc7_t ref_crc7(logic [39:0] d);
		crc7_t c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = d[i] ^ c[6];
			c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return c;
	endfunction

	// same contents the card model holds
	function automatic word_t expected_card_word(sector_t sector, int idx);
		return (sector * 32'h9e37_79b9) ^ {idx[7:0], idx[7:0] ^ 8'ha5, sector[15:0] + 16'(idx)};
	endfunction

	task automatic read_status(output status_t s);
		@(negedge clk);
		avs_read = 1'b1;
		avs_address = REG_BASE;
		#1;
		s = status_t'(avs_readdata[1:0]);
	endtask

	task automatic host_write(reg_addr_t a, word_t d);
		int n;
		n = 0;
		@(negedge clk);
		while (avs_waitrequest) begin
			n++;
			if (n > 100) begin
				report_failure("slave port stuck in waitrequest");
			end
			@(negedge clk);
		end
		avs_read = 1'b0;
		avs_write = 1'b1;
		avs_address = a;
		avs_writedata = d;
		@(negedge clk);
		avs_write = 1'b0;
	endtask

	task automatic wait_status(status_t exp, int limit);
		status_t s;
		int n;
		n = 0;
		read_status(s);
		while (s != exp) begin
			n++;
			if (n > limit) begin
				report_failure($sformatf("status never reached %s", exp.name()));
			end
			read_status(s);
		end
	endtask

	// waits for the read to start and then to leave STATUS_READ
	task automatic wait_done(status_t exp, int limit);
		status_t s;
		int n;
		wait_status(STATUS_READ, 50);
		n = 0;
		read_status(s);
		while (s == STATUS_READ) begin
			n++;
			if (n > limit) begin
				report_failure("read did not finish in time");
			end
			read_status(s);
		end
		check_status("status", s, exp);
	endtask

	task automatic start_read(word_t base, sector_t sector, int nblocks);
		mem.delete();
		writes.delete();
		host_write(REG_BASE, base);
		host_write(REG_SECTOR, sector);
		host_write(REG_COUNT, word_t'(nblocks));
		host_write(REG_CONTROL, word_t'(CONTROL_READ));
	endtask

	task automatic check_memory(word_t base, sector_t sector, int nblocks);
		word_t a;
		word_t raw;
		if (mem.num() != nblocks * WORDS_PER_BLOCK) begin
			report_failure("wrong number of distinct memory words written");
		end
		for (int k = 0; k < nblocks; k++) begin
			for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
				a = base + word_t'(k * BLOCK_BYTES + 4 * i);
				if (!mem.exists(a) || writes[a] != 1) begin
					report_failure($sformatf("word at %h missing or written twice", a));
				end
				raw = expected_card_word(sector + sector_t'(k), i);
				check_word("memory word", mem[a], {raw[7:0], raw[15:8], raw[23:16], raw[31:24]});
			end
		end
	endtask

	task automatic run_read(int nblocks, int pct);
		word_t base;
		sector_t sector;
		int c0;
		base = $urandom & 32'hffff_fffc;
		sector = $urandom;
		wait_pct = pct;
		fault = 3'd0;
		c0 = card_cmds;
		advance_cycles = 0;
		start_read(base, sector, nblocks);
		wait_done(STATUS_IDLE, 120000 * nblocks);
		if (card_cmds - c0 != nblocks) begin
			report_failure("card saw the wrong number of commands");
		end
		if (card_crc_bad != 0) begin
			report_failure("card saw a command with a bad CRC7");
		end
		check_word("card command index", word_t'(card_index), word_t'(CMD_READ_SINGLE));
		check_sector("card command argument", card_arg, sector + sector_t'(nblocks - 1));
		check_word("avs_waitrequest cycles", word_t'(advance_cycles), word_t'(nblocks));
		check_memory(base, sector, nblocks);
	endtask

	task automatic run_fault(logic [2:0] code);
		wait_pct = 30;
		fault = code;
		start_read($urandom & 32'hffff_fffc, $urandom, 1);
		wait_done(STATUS_ERROR, 400000);
		host_write(REG_CONTROL, word_t'(CONTROL_IDLE));
		wait_status(STATUS_IDLE, 50);
		fault = 3'd0;
	endtask

	initial begin
		status_t s;
		reply_t exp_reply;
		void'($urandom(32'h6e93caf3));
		rst_n = 1'b0;
		avs_address = REG_BASE;
		avs_read = 1'b0;
		avs_write = 1'b0;
		avs_writedata = '0;
		fault = 3'd0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		read_status(s);
		check_status("status after reset", s, STATUS_IDLE);
		check_word("sd_clk after reset", word_t'(sd_clk), '0);
		check_word("avm_write after reset", word_t'(avm_write), '0);
		check_word("sd_cmd_oe after reset", word_t'(sd_cmd_oe), '0);

		run_read(1, 20);
		exp_reply = {2'b00, CMD_READ_SINGLE, 32'h0000_0900, 7'd0, 1'b1};
		exp_reply[7:1] = ref_crc7(exp_reply[47:8]);
		check_reply("R1 reply", dut0.u_cmd_engine.reply, exp_reply);
		run_read(2 + $urandom % 3, 30);
		run_read(2, 85);

		// card faults followed by clean reads
		run_fault(3'd1);
		run_read(1, 40);
		run_fault(3'd2);
		run_read(1, 40);
		run_fault(3'd3);
		run_fault(3'd4);
		run_read(1, 10);

		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: compile.f
sd_pkg.sv
sd_clock_gen.sv
sd_cmd_engine.sv
sd_data_reader.sv
sd_bus_master.sv
sd_read_ctrl.sv
sd_block_reader.sv
sd_block_reader_asserts.sv
sd_card_model.sv
tb_sd_block_reader.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_sd_block_reader -o sim_sd
./obj_dir/sim_sd > sim.log 2>&1 || true
cat sim.log
if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
